//--- src.f
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/soc_wb_if.sv
verilog/soc_arbiter.sv
verilog/soc_mux.sv
verilog/soc_ram.sv
verilog/soc_timer.sv
verilog/soc_gpio.sv
verilog/servant_soc.sv
sim/tb_servant_soc.sv

//--- Bender.yml
package:
  name: servant_soc

sources:
  - files:
      - verilog/soc_bus_pkg.sv
      - verilog/soc_map_pkg.sv
      - verilog/soc_wb_if.sv
      - verilog/soc_arbiter.sv
      - verilog/soc_mux.sv
      - verilog/soc_ram.sv
      - verilog/soc_timer.sv
      - verilog/soc_gpio.sv
      - verilog/servant_soc.sv

  - target: simulation
    files:
      - sim/tb_servant_soc.sv

//--- sim/soc_patterns.txt
# kind adr dat sel exp; W write, R read, I ibus read, B ibus and dbus read together,
# T timer (dat is the gap in cycles), G gpio (exp is the pin); W with exp 1 uses random data.
W 00000000 11223344 f 0
R 00000000 00000000 f 0
I 00000000 00000000 0 0
W 00000000 aabbccdd 1 0
R 00000000 00000000 f 0
W 00000000 55667788 6 0
R 00000000 00000000 f 0
I 00000000 00000000 0 0
W 00000004 00000000 f 1
R 00000004 00000000 f 0
W 00000004 00000000 a 1
R 00000004 00000000 f 0
W 00000010 00000000 f 1
W 00000100 00000000 f 1
W 00000ffc 00000000 f 1
R 00000010 00000000 f 0
R 00000100 00000000 f 0
R 00000ffc 00000000 f 0
I 00000ffc 00000000 0 0
B 00000010 00000000 0 0
B 00000100 00000000 0 0
G 80000000 00000001 0 1
G 80000000 fffffffe 0 0
G 80000000 00000003 0 1
T c0000000 0000000a 0 0
W 40000000 deadbeef f 0
R 40000000 00000000 f 0
R 00000000 00000000 f 0

//--- sim/tb_servant_soc.sv
`timescale 1ns/1ps

module tb_servant_soc;

   localparam int    CLK_PERIOD   = 100;
   localparam int    RST_CYCLES   = 8;
   localparam int    ACK_LIMIT    = 16;
   localparam int    LINE_CYCLES  = 40;
   localparam string PATTERN_FILE = "sim/soc_patterns.txt";

   logic        i_wb_clk;
   logic        i_arst_n;
   logic [31:0] i_ibus_adr;
   logic        i_ibus_cyc;
   logic [31:0] o_ibus_rdt;
   logic        o_ibus_ack;
   logic [31:0] i_dbus_adr;
   logic [31:0] i_dbus_dat;
   logic [3:0]  i_dbus_sel;
   logic        i_dbus_we;
   logic        i_dbus_cyc;
   logic [31:0] o_dbus_rdt;
   logic        o_dbus_ack;
   logic        o_gpio;
   logic        o_timer_irq;

   logic [31:0] sb_mem [1024]; // mirrors the RAM and is indexed by address bits 11:2.
   byte         q_kind [$];
   logic [31:0] q_adr [$];
   logic [31:0] q_dat [$];
   logic [3:0]  q_sel [$];
   logic [31:0] q_exp [$];
   int          seed = 35395;
   int          pass_count = 0;
   int          fail_count = 0;
   int          errors = 0;
   bit          loaded = 1'b0;

   servant_soc UUT (
      .i_wb_clk    (i_wb_clk),
      .i_arst_n    (i_arst_n),
      .i_ibus_adr  (i_ibus_adr),
      .i_ibus_cyc  (i_ibus_cyc),
      .o_ibus_rdt  (o_ibus_rdt),
      .o_ibus_ack  (o_ibus_ack),
      .i_dbus_adr  (i_dbus_adr),
      .i_dbus_dat  (i_dbus_dat),
      .i_dbus_sel  (i_dbus_sel),
      .i_dbus_we   (i_dbus_we),
      .i_dbus_cyc  (i_dbus_cyc),
      .o_dbus_rdt  (o_dbus_rdt),
      .o_dbus_ack  (o_dbus_ack),
      .o_gpio      (o_gpio),
      .o_timer_irq (o_timer_irq)
   );

   initial begin
      i_wb_clk = 1'b0;
      forever #(CLK_PERIOD/2) i_wb_clk = ~i_wb_clk;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, act);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("FAILURE at %0t ns: %s", $time, what);
      errors++;
   endtask

   function automatic void store_word(input logic [31:0] adr, input logic [31:0] dat,
                                      input logic [3:0] sel);
      for (int i = 0; i < 4; i++) begin
         if (sel[i])
            sb_mem[adr[11:2]][8*i +: 8] = dat[8*i +: 8]; // only selected lanes change.
      end
   endfunction

   task automatic load_patterns();
      int                 fd;
      int                 code;
      string              token;
      logic [8*256-1:0]   rest;
      logic [31:0]        adr, dat, sel, exp;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         $display("FAILURE: cannot open %s", PATTERN_FILE);
         fail_count++;
         return;
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", token);
         if (code != 1)
            break;
         if (token.getc(0) == "#") begin
            code = $fgets(rest, fd); // skip the rest of a comment line.
         end else begin
            code = $fscanf(fd, "%h %h %h %h", adr, dat, sel, exp);
            if (code != 4) begin
               $display("FAILURE: malformed pattern line after kind %s", token);
               fail_count++;
               break;
            end
            q_kind.push_back(token.getc(0));
            q_adr.push_back(adr);
            q_dat.push_back(dat);
            q_sel.push_back(sel[3:0]);
            q_exp.push_back(exp);
         end
      end
      $fclose(fd);
   endtask

   task automatic dbus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdt, output logic ok);
      int n;
      ok = 1'b0;
      rdt = '0;
      n = 0;
      @(posedge i_wb_clk);
      i_dbus_adr <= adr;
      i_dbus_dat <= dat;
      i_dbus_sel <= sel;
      i_dbus_we  <= we;
      i_dbus_cyc <= 1'b1;
      while (!ok && n < ACK_LIMIT) begin
         @(negedge i_wb_clk);
         if (o_dbus_ack) begin
            ok = 1'b1;
            rdt = o_dbus_rdt;
         end
         n++;
      end
      @(posedge i_wb_clk);
      i_dbus_cyc <= 1'b0;
      i_dbus_we  <= 1'b0;
      if (!ok)
         report_failure($sformatf("no ack within 16 cycles on the dbus at %h", adr));
   endtask

   task automatic ibus_read(input logic [31:0] adr, output logic [31:0] rdt, output logic ok);
      int n;
      ok = 1'b0;
      rdt = '0;
      n = 0;
      @(posedge i_wb_clk);
      i_ibus_adr <= adr;
      i_ibus_cyc <= 1'b1;
      while (!ok && n < ACK_LIMIT) begin
         @(negedge i_wb_clk);
         if (o_ibus_ack) begin
            ok = 1'b1;
            rdt = o_ibus_rdt;
         end
         n++;
      end
      @(posedge i_wb_clk);
      i_ibus_cyc <= 1'b0;
      if (!ok)
         report_failure($sformatf("no ack within 16 cycles on the ibus at %h", adr));
   endtask

   // both masters raise cyc on the same edge and each drops it after its own ack.
   task automatic dual_read(input logic [31:0] iadr, input logic [31:0] dadr,
                            output logic [31:0] irdt, output logic [31:0] drdt,
                            output logic dbus_first, output logic overlap);
      logic idone, ddone;
      int   n;
      idone = 1'b0;
      ddone = 1'b0;
      dbus_first = 1'b0;
      overlap = 1'b0;
      irdt = '0;
      drdt = '0;
      n = 0;
      @(posedge i_wb_clk);
      i_ibus_adr <= iadr;
      i_ibus_cyc <= 1'b1;
      i_dbus_adr <= dadr;
      i_dbus_sel <= 4'hf;
      i_dbus_we  <= 1'b0;
      i_dbus_cyc <= 1'b1;
      while (!(idone && ddone) && n < ACK_LIMIT) begin
         @(negedge i_wb_clk);
         if (o_ibus_ack && o_dbus_ack)
            overlap = 1'b1;
         if (o_dbus_ack && !ddone) begin
            ddone = 1'b1;
            drdt = o_dbus_rdt;
            dbus_first = !idone;
         end
         if (o_ibus_ack && !idone) begin
            idone = 1'b1;
            irdt = o_ibus_rdt;
         end
         @(posedge i_wb_clk);
         if (ddone)
            i_dbus_cyc <= 1'b0;
         if (idone)
            i_ibus_cyc <= 1'b0;
         n++;
      end
      i_ibus_cyc <= 1'b0;
      i_dbus_cyc <= 1'b0;
      if (!(idone && ddone))
         report_failure("no ack within 16 cycles for one of the two masters");
   endtask

   task automatic finish_test(input string label);
      if (errors == 0) begin
         pass_count++;
         $display("%s passed", label);
      end else begin
         fail_count++;
         $display("%s failed with %0d errors", label, errors);
      end
      errors = 0;
   endtask

   initial begin : watchdog
      longint limit;
      wait (loaded);
      limit = (RST_CYCLES + LINE_CYCLES * q_kind.size()) * CLK_PERIOD;
      #(limit);
      $display("FAILURE: run did not end within %0d ns", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      logic [31:0] rdt, dat, exp, first, second, irdt, drdt;
      logic        ok, dbus_first, overlap, hit;
      i_arst_n   = 1'b0;
      i_ibus_adr = '0;
      i_ibus_cyc = 1'b0;
      i_dbus_adr = '0;
      i_dbus_dat = '0;
      i_dbus_sel = '0;
      i_dbus_we  = 1'b0;
      i_dbus_cyc = 1'b0;
      load_patterns();
      loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge i_wb_clk);
      i_arst_n <= 1'b1;
      @(negedge i_wb_clk);
      if (o_ibus_ack !== 1'b0)
         report_mismatch("o_ibus_ack", 0, o_ibus_ack);
      if (o_dbus_ack !== 1'b0)
         report_mismatch("o_dbus_ack", 0, o_dbus_ack);
      if (o_gpio !== 1'b0)
         report_mismatch("o_gpio", 0, o_gpio);
      if (o_timer_irq !== 1'b0)
         report_mismatch("o_timer_irq", 0, o_timer_irq);
      finish_test("reset");
      for (int n = 0; n < q_kind.size(); n++) begin
         case (q_kind[n])
            "W": begin
               dat = (q_exp[n] == 1) ? $random(seed) : q_dat[n];
               dbus_access(1'b1, q_adr[n], dat, q_sel[n], rdt, ok);
               if (ok && q_adr[n][31:30] == 2'b00)
                  store_word(q_adr[n], dat, q_sel[n]);
            end
            "R": begin
               dbus_access(1'b0, q_adr[n], '0, q_sel[n], rdt, ok);
               exp = (q_adr[n][31:30] == 2'b00) ? sb_mem[q_adr[n][11:2]] : q_exp[n];
               if (ok && rdt !== exp)
                  report_mismatch("o_dbus_rdt", exp, rdt);
            end
            "I": begin
               ibus_read(q_adr[n], rdt, ok);
               if (ok && rdt !== sb_mem[q_adr[n][11:2]])
                  report_mismatch("o_ibus_rdt", sb_mem[q_adr[n][11:2]], rdt);
            end
            "B": begin
               // the data column holds the ibus address, so each master reads its own word.
               dual_read(q_dat[n], q_adr[n], irdt, drdt, dbus_first, overlap);
               if (drdt !== sb_mem[q_adr[n][11:2]])
                  report_mismatch("o_dbus_rdt", sb_mem[q_adr[n][11:2]], drdt);
               if (irdt !== sb_mem[q_dat[n][11:2]])
                  report_mismatch("o_ibus_rdt", sb_mem[q_dat[n][11:2]], irdt);
               if (!dbus_first)
                  report_failure("ibus was acked before dbus");
               if (overlap)
                  report_failure("ibus and dbus were acked in the same cycle");
            end
            "G": begin
               dbus_access(1'b1, q_adr[n], q_dat[n], 4'hf, rdt, ok);
               @(negedge i_wb_clk);
               if (o_gpio !== q_exp[n][0])
                  report_mismatch("o_gpio", q_exp[n][0], o_gpio);
               dbus_access(1'b0, q_adr[n], '0, 4'hf, rdt, ok);
               if (ok && rdt !== {31'b0, q_exp[n][0]})
                  report_mismatch("o_dbus_rdt", {31'b0, q_exp[n][0]}, rdt);
            end
            "T": begin
               dbus_access(1'b0, q_adr[n], '0, 4'hf, first, ok);
               repeat (q_dat[n]) @(posedge i_wb_clk);
               dbus_access(1'b0, q_adr[n], '0, 4'hf, second, ok);
               if (second <= first)
                  report_failure($sformatf("timer count went from %h to %h", first, second));
               dbus_access(1'b1, q_adr[n], first + 32'd20, 4'hf, rdt, ok);
               hit = 1'b0;
               for (int c = 0; c < 40 && !hit; c++) begin
                  @(negedge i_wb_clk);
                  hit = o_timer_irq;
               end
               if (!hit)
                  report_failure("timer interrupt not raised within 40 cycles");
               dbus_access(1'b1, q_adr[n], 32'hffff_ffff, 4'hf, rdt, ok);
               hit = 1'b1;
               for (int c = 0; c < 2 && hit; c++) begin
                  @(negedge i_wb_clk);
                  hit = o_timer_irq;
               end
               if (hit)
                  report_failure("timer interrupt still high 2 cycles after compare reset");
            end
            default: report_failure($sformatf("unknown pattern kind %c", q_kind[n]));
         endcase
         finish_test($sformatf("line %0d (%c %h)", n + 1, q_kind[n], q_adr[n]));
      end
      $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- verilog/servant_soc.sv
`timescale 1ns/1ps

module servant_soc
   import soc_bus_pkg::*;
   import soc_map_pkg::*;
(
   input  logic             i_wb_clk,
   input  logic             i_arst_n,
   input  logic [ADR_W-1:0] i_ibus_adr,
   input  logic             i_ibus_cyc,
   output logic [DAT_W-1:0] o_ibus_rdt,
   output logic             o_ibus_ack,
   input  logic [ADR_W-1:0] i_dbus_adr,
   input  logic [DAT_W-1:0] i_dbus_dat,
   input  logic [SEL_W-1:0] i_dbus_sel,
   input  logic             i_dbus_we,
   input  logic             i_dbus_cyc,
   output logic [DAT_W-1:0] o_dbus_rdt,
   output logic             o_dbus_ack,
   output logic             o_gpio,
   output logic             o_timer_irq
);

   soc_wb_if mem_dbus_if ();
   soc_wb_if mem_if ();
   soc_wb_if gpio_if ();
   soc_wb_if timer_if ();

   soc_mux mux (
      .i_wb_clk   (i_wb_clk),
      .i_arst_n   (i_arst_n),
      .i_dbus_adr (i_dbus_adr),
      .i_dbus_dat (i_dbus_dat),
      .i_dbus_sel (i_dbus_sel),
      .i_dbus_we  (i_dbus_we),
      .i_dbus_cyc (i_dbus_cyc),
      .o_dbus_rdt (o_dbus_rdt),
      .o_dbus_ack (o_dbus_ack),
      .mem        (mem_dbus_if.master),
      .gpio       (gpio_if.master),
      .timer      (timer_if.master)
   );

   soc_arbiter arbiter (
      .i_wb_clk   (i_wb_clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .dbus       (mem_dbus_if.slave),
      .mem        (mem_if.master)
   );

   soc_ram ram (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .bus      (mem_if.slave)
   );

   soc_timer timer (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .bus      (timer_if.slave),
      .o_irq    (o_timer_irq)
   );

   soc_gpio gpio (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .bus      (gpio_if.slave),
      .o_gpio   (o_gpio)
   );

endmodule

//--- verilog/soc_gpio.sv
`timescale 1ns/1ps

module soc_gpio
   import soc_bus_pkg::*;
(
   input  logic     i_wb_clk,
   input  logic     i_arst_n,
   soc_wb_if.slave  bus,
   output logic     o_gpio
);

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_gpio <= 1'b0;
      else if (bus.cyc && bus.we)
         o_gpio <= bus.dat[0]; // upper data bits are ignored.
   end

   assign bus.rdt = {{(DAT_W-1){1'b0}}, o_gpio};

endmodule

//--- verilog/soc_timer.sv
`timescale 1ns/1ps

module soc_timer
   import soc_bus_pkg::*;
   import soc_map_pkg::*;
(
   input  logic     i_wb_clk,
   input  logic     i_arst_n,
   soc_wb_if.slave  bus,
   output logic     o_irq
);

   logic [DAT_W-1:0] count;
   logic [DAT_W-1:0] cmp;

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         count <= '0;
         cmp   <= TMR_CMP_RESET;
         o_irq <= 1'b0;
      end else begin
         count <= count + 1'b1; // free running, wraps.
         if (bus.cyc && bus.we)
            cmp <= bus.dat;
         o_irq <= (count >= cmp); // level, held until compare moves past the count.
      end
   end

   // a read always sees the live counter.
   assign bus.rdt = count;

endmodule

//--- verilog/soc_ram.sv
`timescale 1ns/1ps

module soc_ram
   import soc_bus_pkg::*;
   import soc_map_pkg::*;
(
   input  logic     i_wb_clk,
   input  logic     i_arst_n,
   soc_wb_if.slave  bus
);

   logic [DAT_W-1:0]  mem [RAM_WORDS];
   logic [DAT_W-1:0]  rdt_q;
   logic [RAM_AW-1:0] word_adr;
   logic              ack_q;

   assign word_adr = bus.adr[RAM_AW+1:2];

   always_ff @(posedge i_wb_clk) begin
      if (bus.cyc && !ack_q && bus.we) begin
         for (int i = 0; i < SEL_W; i++) begin
            if (bus.sel[i])
               mem[word_adr][8*i +: 8] <= bus.dat[8*i +: 8];
         end
      end
   end

   // read data lands together with the ack.
   always_ff @(posedge i_wb_clk) begin
      if (bus.cyc)
         rdt_q <= mem[word_adr];
   end

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         ack_q <= 1'b0;
      else
         ack_q <= bus.cyc & ~ack_q; // a held cyc gets a gap before the next ack.
   end

   assign bus.rdt = rdt_q;
   assign bus.ack = ack_q;

   a_ack_pulse : assert property (
      @(posedge i_wb_clk) disable iff (!i_arst_n)
      ack_q |=> !ack_q)
      else $error("RAM ack high for two cycles");

endmodule

//--- verilog/soc_mux.sv
`timescale 1ns/1ps

module soc_mux
   import soc_bus_pkg::*;
   import soc_map_pkg::*;
(
   input  logic             i_wb_clk,
   input  logic             i_arst_n,
   input  logic [ADR_W-1:0] i_dbus_adr,
   input  logic [DAT_W-1:0] i_dbus_dat,
   input  logic [SEL_W-1:0] i_dbus_sel,
   input  logic             i_dbus_we,
   input  logic             i_dbus_cyc,
   output logic [DAT_W-1:0] o_dbus_rdt,
   output logic             o_dbus_ack,
   soc_wb_if.master         mem,
   soc_wb_if.master         gpio,
   soc_wb_if.master         timer
);

   region_t region;
   logic    periph_cyc;
   logic    periph_ack;

   assign region = region_t'(i_dbus_adr[REG_MSB:REG_LSB]);

   // the request is broadcast, only the selected target sees cyc.
   assign mem.adr   = i_dbus_adr;
   assign mem.dat   = i_dbus_dat;
   assign mem.sel   = i_dbus_sel;
   assign mem.we    = i_dbus_we;
   assign mem.cyc   = i_dbus_cyc & (region == REG_MEM);

   assign gpio.adr  = i_dbus_adr;
   assign gpio.dat  = i_dbus_dat;
   assign gpio.sel  = i_dbus_sel;
   assign gpio.we   = i_dbus_we;
   assign gpio.cyc  = i_dbus_cyc & (region == REG_GPIO);

   assign timer.adr = i_dbus_adr;
   assign timer.dat = i_dbus_dat;
   assign timer.sel = i_dbus_sel;
   assign timer.we  = i_dbus_we;
   assign timer.cyc = i_dbus_cyc & (region == REG_TIMER);

   // gpio, timer and the hole all answer one cycle after cyc.
   assign periph_cyc = i_dbus_cyc & (region != REG_MEM);

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         periph_ack <= 1'b0;
      else
         periph_ack <= periph_cyc & ~periph_ack; // one cycle per access.
   end

   assign o_dbus_ack = periph_ack | mem.ack;

   always_comb begin
      case (region)
         REG_MEM:   o_dbus_rdt = mem.rdt;
         REG_GPIO:  o_dbus_rdt = gpio.rdt;
         REG_TIMER: o_dbus_rdt = timer.rdt;
         default:   o_dbus_rdt = '0; // the hole reads as zero.
      endcase
   end

   a_one_target : assert property (
      @(posedge i_wb_clk) disable iff (!i_arst_n)
      $onehot0({mem.cyc, gpio.cyc, timer.cyc}))
      else $error("more than one dbus target selected");

endmodule

//--- verilog/soc_arbiter.sv
`timescale 1ns/1ps

module soc_arbiter
   import soc_bus_pkg::*;
(
   input  logic             i_wb_clk,
   input  logic             i_arst_n,
   input  logic [ADR_W-1:0] i_ibus_adr,
   input  logic             i_ibus_cyc,
   output logic [DAT_W-1:0] o_ibus_rdt,
   output logic             o_ibus_ack,
   soc_wb_if.slave          dbus,
   soc_wb_if.master         mem
);

   arb_state_t state;
   arb_state_t grant;

   // from idle the grant is immediate and dbus wins a tie.
   always_comb begin
      grant = state;
      if (state == ARB_IDLE) begin
         if (dbus.cyc)
            grant = ARB_DBUS;
         else if (i_ibus_cyc)
            grant = ARB_IBUS;
      end
   end

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         state <= ARB_IDLE;
      else if (mem.ack)
         state <= ARB_IDLE; // release after the granted access completes.
      else
         state <= grant;
   end

   assign mem.adr = (grant == ARB_IBUS) ? i_ibus_adr : dbus.adr;
   assign mem.dat = dbus.dat;
   assign mem.sel = dbus.sel;
   assign mem.we  = dbus.we & (grant == ARB_DBUS); // the ibus only reads.
   assign mem.cyc = ((grant == ARB_DBUS) & dbus.cyc) | ((grant == ARB_IBUS) & i_ibus_cyc);

   assign dbus.rdt   = mem.rdt;
   assign dbus.ack   = mem.ack & (grant == ARB_DBUS);
   assign o_ibus_rdt = mem.rdt;
   assign o_ibus_ack = mem.ack & (grant == ARB_IBUS);

   a_single_ack : assert property (
      @(posedge i_wb_clk) disable iff (!i_arst_n)
      !(o_ibus_ack && dbus.ack))
      else $error("ibus and dbus acked in the same cycle");

   a_grant_locked : assert property (
      @(posedge i_wb_clk) disable iff (!i_arst_n)
      ((state == ARB_IBUS || state == ARB_DBUS) && !mem.ack) |=> (state == $past(state)))
      else $error("arbiter grant released without a memory ack");

endmodule

//--- verilog/soc_wb_if.sv
`timescale 1ns/1ps

interface soc_wb_if
   import soc_bus_pkg::*;
   ();

   logic [ADR_W-1:0] adr;
   logic [DAT_W-1:0] dat;
   logic [SEL_W-1:0] sel;
   logic             we;
   logic             cyc; // held high with stable request until ack.
   logic [DAT_W-1:0] rdt; // valid in the ack cycle.
   logic             ack;

   modport master (
      output adr, dat, sel, we, cyc,
      input  rdt, ack
   );

   modport slave (
      input  adr, dat, sel, we, cyc,
      output rdt, ack
   );

endinterface

//--- verilog/soc_map_pkg.sv
package soc_map_pkg;

   // the top two address bits select the region.
   localparam int REG_MSB = 31;
   localparam int REG_LSB = 30;

   typedef enum logic [1:0] {
      REG_MEM   = 2'b00,
      REG_HOLE  = 2'b01, // unmapped, reads return zero.
      REG_GPIO  = 2'b10,
      REG_TIMER = 2'b11
   } region_t;

   // word RAM, addressed by bus address bits 11:2.
   localparam int RAM_WORDS = 1024;
   localparam int RAM_AW    = 10; // higher bits inside the memory region alias.

   // compare value after reset keeps the timer interrupt quiet.
   localparam logic [31:0] TMR_CMP_RESET = 32'hFFFF_FFFF;

endpackage

//--- verilog/soc_bus_pkg.sv
package soc_bus_pkg;

   // widths shared by every Wishbone port in the fabric.
   localparam int ADR_W = 32;
   localparam int DAT_W = 32;
   localparam int SEL_W = 4; // one select bit per byte lane.

   // the arbiter is idle or locked to one master until that master's ack.
   typedef enum logic [1:0] {
      ARB_IDLE = 2'b00,
      ARB_IBUS = 2'b01,
      ARB_DBUS = 2'b10
   } arb_state_t;

endpackage
